//--- rtl/csi2_rx_pkg.sv
package csi2_rx_pkg;

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////

localparam int CSI2_WORD_W = 32;                  // Merged lane word.
localparam int CSI2_BE_W   = CSI2_WORD_W / 8;
localparam int CSI2_WC_W   = 16;
localparam int CSI2_DI_W   = 8;
localparam int CSI2_DT_W   = 6;                   // Low bits of data id.
localparam int CSI2_CRC_W  = 16;
localparam int CSI2_CNT_W  = 16;                  // Packet counters.

typedef logic [CSI2_WORD_W - 1 : 0] csi2_word_t;
typedef logic [CSI2_BE_W - 1 : 0]   csi2_be_t;
typedef logic [CSI2_WC_W - 1 : 0]   csi2_wc_t;
typedef logic [CSI2_DI_W - 1 : 0]   csi2_di_t;
typedef logic [CSI2_CRC_W - 1 : 0]  crc16_t;

////////////////////////////////////////////////////////////////////////////
// Protocol constants
////////////////////////////////////////////////////////////////////////////

localparam crc16_t CSI2_CRC_POLY = 16'h1021;
localparam crc16_t CSI2_CRC_INIT = 16'hffff;

// Data types up to this value are short packets.
localparam logic [CSI2_DT_W - 1 : 0] CSI2_SHORT_DT_MAX = 6'h0f;

////////////////////////////////////////////////////////////////////////////
// Structs and state
////////////////////////////////////////////////////////////////////////////

typedef struct packed {
  csi2_di_t di;
  csi2_wc_t wc;
} pkt_info_t;

typedef struct packed {
  csi2_word_t word;
  logic       valid;
  logic       eop;
  csi2_be_t   be;                                 // Meaningful tail bytes.
} pkt_stream_t;

typedef struct packed {
  csi2_di_t di;
  csi2_wc_t wc;
  logic     is_long;
  logic     crc_ok;
} pkt_result_t;

typedef enum logic [1 : 0] {
  IDLE,
  PAYLOAD,
  TAIL
} dec_state_t;

endpackage

//--- rtl/crc_calc.sv
`timescale 1ns/1ps

module crc_calc #(
  parameter int                    CRC_SIZE   = 16,
  parameter int                    DATA_WIDTH = 32,
  parameter logic [CRC_SIZE - 1 : 0] POLY     = 16'h1021,
  parameter logic [CRC_SIZE - 1 : 0] INIT     = '1,
  parameter bit                    REF_IN     = 1'b1,
  parameter bit                    REF_OUT    = 1'b1,
  parameter logic [CRC_SIZE - 1 : 0] XOR_OUT  = '0
)
(
  input                             clk_i,
  input                             rst_i,
  input                             soft_reset_i,
  input                             valid_i,
  input        [DATA_WIDTH - 1 : 0] data_i,
  output logic [CRC_SIZE - 1 : 0]   crc_o
);

logic [CRC_SIZE - 1 : 0] crc_q;
logic [CRC_SIZE - 1 : 0] crc_next;
logic [CRC_SIZE - 1 : 0] crc_out_ref;
logic                    feedback;

// MSB-first shift over every data bit in one cycle.
always_comb
  begin
    crc_next = crc_q;
    feedback = 1'b0;
    for( int i = 0; i < DATA_WIDTH; i++ )
      begin
        if( REF_IN )
          feedback = crc_next[CRC_SIZE - 1] ^ data_i[i];  // Bytes LSB first.
        else
          feedback = crc_next[CRC_SIZE - 1] ^ data_i[DATA_WIDTH - 1 - i];
        crc_next = { crc_next[CRC_SIZE - 2 : 0], 1'b0 };
        if( feedback )
          crc_next = crc_next ^ POLY;
      end
  end

always_ff @( posedge clk_i )
  if( rst_i || soft_reset_i )
    crc_q <= INIT;
  else
    if( valid_i )
      crc_q <= crc_next;

always_comb
  begin
    for( int i = 0; i < CRC_SIZE; i++ )
      crc_out_ref[i] = crc_q[CRC_SIZE - 1 - i];
  end

assign crc_o = ( REF_OUT ? crc_out_ref : crc_q ) ^ XOR_OUT;

endmodule

//--- rtl/csi2_crc_calc.sv
`timescale 1ns/1ps

module csi2_crc_calc
(
  input                            clk_i,
  input                            rst_i,
  input  csi2_rx_pkg::csi2_word_t  long_pkt_payload_i,
  input                            long_pkt_payload_valid_i,
  input  csi2_rx_pkg::csi2_be_t    long_pkt_payload_be_i,
  input                            long_pkt_eop_i,
  output logic                     crc_passed_o,
  output logic                     crc_failed_o
);

csi2_rx_pkg::crc16_t main_crc;
csi2_rx_pkg::crc16_t crc_8bit;
csi2_rx_pkg::crc16_t crc_16bit;
csi2_rx_pkg::crc16_t crc_24bit;
csi2_rx_pkg::crc16_t residue;
logic                long_pkt_eop_d1;

// One byte through the reflected register, LSB first.
function automatic csi2_rx_pkg::crc16_t fold_byte(
  input csi2_rx_pkg::crc16_t crc,
  input logic [7 : 0]        data
);
  csi2_rx_pkg::crc16_t c;
  logic                fb;
  c = crc;
  for( int i = 0; i < 8; i++ )
    begin
      fb = c[0] ^ data[i];
      c  = c >> 1;
      for( int j = 0; j < csi2_rx_pkg::CSI2_CRC_W; j++ )
        if( csi2_rx_pkg::CSI2_CRC_POLY[j] )
          c[csi2_rx_pkg::CSI2_CRC_W - 1 - j] = c[csi2_rx_pkg::CSI2_CRC_W - 1 - j] ^ fb;
    end
  return c;
endfunction

always_ff @( posedge clk_i )
  if( rst_i )
    long_pkt_eop_d1 <= 1'b0;
  else
    long_pkt_eop_d1 <= long_pkt_eop_i;

crc_calc #(
  .CRC_SIZE     ( csi2_rx_pkg::CSI2_CRC_W    ),
  .DATA_WIDTH   ( csi2_rx_pkg::CSI2_WORD_W   ),
  .POLY         ( csi2_rx_pkg::CSI2_CRC_POLY ),
  .INIT         ( csi2_rx_pkg::CSI2_CRC_INIT ),
  .REF_IN       ( 1'b1                       ),
  .REF_OUT      ( 1'b1                       ),
  .XOR_OUT      ( '0                         )
) i_crc_calc (
  .clk_i        ( clk_i                      ),
  .rst_i        ( rst_i                      ),
  .soft_reset_i ( long_pkt_eop_d1            ),  // Ready for next packet.
  .valid_i      ( long_pkt_payload_valid_i   ),
  .data_i       ( long_pkt_payload_i         ),
  .crc_o        ( main_crc                   )
);

////////////////////////////////////////////////////////////////////////////
// Tail bytes folded on top of the full words
////////////////////////////////////////////////////////////////////////////

assign crc_8bit  = fold_byte( main_crc,  long_pkt_payload_i[7 : 0]   );
assign crc_16bit = fold_byte( crc_8bit,  long_pkt_payload_i[15 : 8]  );
assign crc_24bit = fold_byte( crc_16bit, long_pkt_payload_i[23 : 16] );

always_comb
  case( long_pkt_payload_be_i )
    4'b0001: residue = crc_8bit;
    4'b0011: residue = crc_16bit;
    4'b0111: residue = crc_24bit;
    default: residue = main_crc;                  // All four bytes taken.
  endcase

// Payload followed by its own CRC leaves zero.
assign crc_passed_o = long_pkt_eop_d1 && ( residue == '0 );
assign crc_failed_o = long_pkt_eop_d1 && ( residue != '0 );

endmodule

//--- rtl/csi2_pkt_decode.sv
`timescale 1ns/1ps

module csi2_pkt_decode
(
  input                                clk_i,
  input                                rst_i,
  input                                word_valid_i,
  input  csi2_rx_pkg::csi2_word_t      word_i,
  output csi2_rx_pkg::pkt_stream_t     stream_o,
  output csi2_rx_pkg::pkt_info_t       info_o,
  output logic                         short_pkt_o
);

csi2_rx_pkg::dec_state_t             state;
csi2_rx_pkg::csi2_di_t               hdr_di;
csi2_rx_pkg::csi2_wc_t               hdr_wc;
logic                                hdr_short;
logic [csi2_rx_pkg::CSI2_WC_W : 0]   rem_bytes;   // Payload plus CRC left.
csi2_rx_pkg::csi2_be_t               tail_be;

csi2_rx_pkg::csi2_word_t             out_word;
logic                                out_valid;
logic                                out_eop;
csi2_rx_pkg::csi2_be_t               out_be;

////////////////////////////////////////////////////////////////////////////
// Header fields
////////////////////////////////////////////////////////////////////////////

assign hdr_di    = word_i[csi2_rx_pkg::CSI2_DI_W - 1 : 0];
assign hdr_wc    = word_i[csi2_rx_pkg::CSI2_DI_W +: csi2_rx_pkg::CSI2_WC_W];
assign hdr_short = hdr_di[csi2_rx_pkg::CSI2_DT_W - 1 : 0] <= csi2_rx_pkg::CSI2_SHORT_DT_MAX;

always_comb
  case( rem_bytes[1 : 0] )
    2'd1:    tail_be = 4'b0001;
    2'd2:    tail_be = 4'b0011;
    default: tail_be = 4'b0111;
  endcase

////////////////////////////////////////////////////////////////////////////
// Packet FSM
////////////////////////////////////////////////////////////////////////////

always_ff @( posedge clk_i )
  if( rst_i )
    begin
      state       <= csi2_rx_pkg::IDLE;
      rem_bytes   <= '0;
      out_valid   <= 1'b0;
      out_eop     <= 1'b0;
      out_be      <= '1;
      short_pkt_o <= 1'b0;
    end
  else
    begin
      out_valid   <= 1'b0;
      out_eop     <= 1'b0;
      short_pkt_o <= 1'b0;
      case( state )
        csi2_rx_pkg::IDLE:
          begin
            out_be <= '1;                         // Back to full words.
            if( word_valid_i )
              begin
                if( hdr_short )
                  short_pkt_o <= 1'b1;
                else
                  begin
                    rem_bytes <= hdr_wc + 2'd2;   // CRC bytes included.
                    state     <= csi2_rx_pkg::PAYLOAD;
                  end
              end
          end
        csi2_rx_pkg::PAYLOAD:
          if( word_valid_i )
            begin
              if( rem_bytes > 4 )
                begin
                  out_valid <= 1'b1;
                  rem_bytes <= rem_bytes - 3'd4;
                end
              else
                if( rem_bytes == 4 )
                  begin
                    out_valid <= 1'b1;
                    out_eop   <= 1'b1;
                    state     <= csi2_rx_pkg::IDLE;
                  end
                else
                  begin
                    out_eop <= 1'b1;              // Partial word, no valid.
                    state   <= csi2_rx_pkg::TAIL;
                  end
            end
        csi2_rx_pkg::TAIL:
          begin
            out_be <= tail_be;                    // Checker folds these.
            state  <= csi2_rx_pkg::IDLE;
          end
        default:
          state <= csi2_rx_pkg::IDLE;
      endcase
    end

// Word and header registers.
always_ff @( posedge clk_i )
  if( word_valid_i )
    begin
      if( state == csi2_rx_pkg::IDLE )
        begin
          info_o.di <= hdr_di;
          info_o.wc <= hdr_wc;
        end
      else
        if( state == csi2_rx_pkg::PAYLOAD )
          out_word <= word_i;
    end

assign stream_o = '{ word:  out_word,
                     valid: out_valid,
                     eop:   out_eop,
                     be:    out_be };

endmodule

//--- rtl/csi2_pkt_result.sv
`timescale 1ns/1ps

module csi2_pkt_result
(
  input                                          clk_i,
  input                                          rst_i,
  input  csi2_rx_pkg::pkt_info_t                 info_i,
  input                                          short_pkt_i,
  input                                          crc_passed_i,
  input                                          crc_failed_i,
  output csi2_rx_pkg::pkt_result_t               result_o,
  output logic                                   result_valid_o,
  output logic [csi2_rx_pkg::CSI2_CNT_W - 1 : 0] good_cnt_o,
  output logic [csi2_rx_pkg::CSI2_CNT_W - 1 : 0] bad_cnt_o
);

logic pkt_done;

assign pkt_done = short_pkt_i || crc_passed_i || crc_failed_i;

always_ff @( posedge clk_i )
  if( rst_i )
    result_valid_o <= 1'b0;
  else
    result_valid_o <= pkt_done;

// Short packets carry no CRC, so crc_ok stays clear.
always_ff @( posedge clk_i )
  if( pkt_done )
    begin
      result_o.di      <= info_i.di;
      result_o.wc      <= info_i.wc;
      result_o.is_long <= !short_pkt_i;
      result_o.crc_ok  <= crc_passed_i;
    end

////////////////////////////////////////////////////////////////////////////
// Long packet counters
////////////////////////////////////////////////////////////////////////////

always_ff @( posedge clk_i )
  if( rst_i )
    begin
      good_cnt_o <= '0;
      bad_cnt_o  <= '0;
    end
  else
    begin
      if( crc_passed_i )
        good_cnt_o <= good_cnt_o + 1'b1;          // Wraps.
      if( crc_failed_i )
        bad_cnt_o  <= bad_cnt_o + 1'b1;
    end

endmodule

//--- rtl/csi2_rx_top.sv
`timescale 1ns/1ps

module csi2_rx_top
(
  input                                          clk_i,
  input                                          rst_i,
  input                                          word_valid_i,
  input  csi2_rx_pkg::csi2_word_t                word_i,
  output csi2_rx_pkg::pkt_result_t               result_o,
  output logic                                   result_valid_o,
  output logic [csi2_rx_pkg::CSI2_CNT_W - 1 : 0] good_cnt_o,
  output logic [csi2_rx_pkg::CSI2_CNT_W - 1 : 0] bad_cnt_o
);

csi2_rx_pkg::pkt_stream_t stream;
csi2_rx_pkg::pkt_info_t   info;
logic                     short_pkt;
logic                     crc_passed;
logic                     crc_failed;

csi2_pkt_decode i_csi2_pkt_decode (
  .clk_i        ( clk_i        ),
  .rst_i        ( rst_i        ),
  .word_valid_i ( word_valid_i ),
  .word_i       ( word_i       ),
  .stream_o     ( stream       ),
  .info_o       ( info         ),
  .short_pkt_o  ( short_pkt    )
);

csi2_crc_calc i_csi2_crc_calc (
  .clk_i                    ( clk_i        ),
  .rst_i                    ( rst_i        ),
  .long_pkt_payload_i       ( stream.word  ),
  .long_pkt_payload_valid_i ( stream.valid ),
  .long_pkt_payload_be_i    ( stream.be    ),
  .long_pkt_eop_i           ( stream.eop   ),
  .crc_passed_o             ( crc_passed   ),
  .crc_failed_o             ( crc_failed   )
);

csi2_pkt_result i_csi2_pkt_result (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .info_i         ( info           ),
  .short_pkt_i    ( short_pkt      ),
  .crc_passed_i   ( crc_passed     ),
  .crc_failed_i   ( crc_failed     ),
  .result_o       ( result_o       ),
  .result_valid_o ( result_valid_o ),
  .good_cnt_o     ( good_cnt_o     ),
  .bad_cnt_o      ( bad_cnt_o      )
);

endmodule

//--- verification/csi2_rx_properties.sv
`timescale 1ns/1ps

module csi2_rx_properties
(
  input                          clk_i,
  input                          rst_i,
  input                          valid_i,
  input                          eop_i,
  input  csi2_rx_pkg::csi2_be_t  be_i,
  input                          crc_passed_i,
  input                          crc_failed_i
);

pass_fail_exclusive: assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  !( crc_passed_i && crc_failed_i )
) else $error( "crc_passed and crc_failed are high in the same cycle" );

eop_gives_verdict: assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  eop_i |=> ( crc_passed_i || crc_failed_i )
) else $error( "No CRC verdict one cycle after eop" );

verdict_needs_eop: assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  ( crc_passed_i || crc_failed_i ) |-> $past( eop_i )
) else $error( "CRC verdict without eop in the cycle before" );

// Partial enables belong to the tail only.
valid_full_word: assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  valid_i |-> ( be_i == 4'b1111 )
) else $error( "Stream valid together with a partial byte enable" );

endmodule

bind csi2_crc_calc csi2_rx_properties i_csi2_rx_properties (
  .clk_i        ( clk_i                    ),
  .rst_i        ( rst_i                    ),
  .valid_i      ( long_pkt_payload_valid_i ),
  .eop_i        ( long_pkt_eop_i           ),
  .be_i         ( long_pkt_payload_be_i    ),
  .crc_passed_i ( crc_passed_o             ),
  .crc_failed_i ( crc_failed_o             )
);

//--- verification/csi2_rx_tb.sv
`timescale 1ns/1ps

module csi2_rx_tb;

typedef struct {
  string                 name;
  csi2_rx_pkg::csi2_di_t di;
  csi2_rx_pkg::csi2_wc_t wc;
  logic                  corrupt;
} test_t;

logic                                   clk_i = 1'b0;
logic                                   rst_i;
logic                                   word_valid_i;
csi2_rx_pkg::csi2_word_t                word_i;
csi2_rx_pkg::pkt_result_t               result_o;
logic                                   result_valid_o;
logic [csi2_rx_pkg::CSI2_CNT_W - 1 : 0] good_cnt_o;
logic [csi2_rx_pkg::CSI2_CNT_W - 1 : 0] bad_cnt_o;

logic [31 : 0] lcg_state = 32'h1232;
int            checks;
int            errors;
int            exp_good;
int            exp_bad;

// Name, data id, word count, corrupt. Bytes mod 4 give the tail case.
test_t tests [13] = '{
  '{ "short_frame_start",  8'h00, 16'h0001, 1'b0 },
  '{ "short_line_end_vc1", 8'h43, 16'h0020, 1'b0 },
  '{ "short_dt_max_vc2",   8'h8f, 16'hbeef, 1'b0 },
  '{ "long_wc0",           8'h2a, 16'd0,    1'b0 },
  '{ "long_wc1",           8'h2a, 16'd1,    1'b0 },
  '{ "long_wc2",           8'h2b, 16'd2,    1'b0 },
  '{ "long_wc3",           8'h2c, 16'd3,    1'b0 },
  '{ "long_wc4",           8'h1e, 16'd4,    1'b0 },
  '{ "long_wc5",           8'h24, 16'd5,    1'b0 },
  '{ "long_wc64_vc3",      8'hd2, 16'd64,   1'b0 },
  '{ "bad_wc2",            8'h2a, 16'd2,    1'b1 },
  '{ "bad_wc5_vc1",        8'h6a, 16'd5,    1'b1 },
  '{ "bad_wc64",           8'h2a, 16'd64,   1'b1 }
};

csi2_rx_top i_csi2_rx_top (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .word_valid_i   ( word_valid_i   ),
  .word_i         ( word_i         ),
  .result_o       ( result_o       ),
  .result_valid_o ( result_valid_o ),
  .good_cnt_o     ( good_cnt_o     ),
  .bad_cnt_o      ( bad_cnt_o      )
);

always
  #50 clk_i = ~clk_i;

////////////////////////////////////////////////////////////////////////////
// Reference models
////////////////////////////////////////////////////////////////////////////

function automatic logic [7 : 0] next_random_byte();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state[23 : 16];
endfunction

// Reflected CRC-16, bytes LSB first, no final XOR.
function automatic csi2_rx_pkg::crc16_t crc16_of( input logic [7 : 0] data [$] );
  csi2_rx_pkg::crc16_t crc;
  csi2_rx_pkg::crc16_t poly_ref;
  for( int i = 0; i < 16; i++ )
    poly_ref[i] = csi2_rx_pkg::CSI2_CRC_POLY[15 - i];
  crc = csi2_rx_pkg::CSI2_CRC_INIT;
  foreach( data[n] )
    begin
      crc = crc ^ data[n];
      for( int b = 0; b < 8; b++ )
        crc = crc[0] ? ( crc >> 1 ) ^ poly_ref : crc >> 1;
    end
  return crc;
endfunction

// Data type sits in the low six bits, long from 0x10 up.
function automatic bit long_data_type( input csi2_rx_pkg::csi2_di_t di );
  return di[5 : 0] >= 6'h10;
endfunction

function automatic int max_packet_words();
  int m;
  m = 1;
  foreach( tests[t] )
    if( 1 + ( int'( tests[t].wc ) + 5 ) / 4 > m )
      m = 1 + ( int'( tests[t].wc ) + 5 ) / 4;    // Header plus payload and CRC.
  return m;
endfunction

////////////////////////////////////////////////////////////////////////////
// Stimulus and checks
////////////////////////////////////////////////////////////////////////////

task automatic check_field( input string test_name, input string field,
                            input logic [31 : 0] expected, input logic [31 : 0] actual );
  checks++;
  assert( actual === expected )
  else
    begin
      errors++;
      $display( "error %s %s: expected %0h, actual %0h", test_name, field, expected, actual );
    end
endtask

task automatic send_word( input csi2_rx_pkg::csi2_word_t w );
  @( posedge clk_i );
  word_valid_i <= 1'b1;
  word_i       <= w;
endtask

task automatic run_test( input test_t t );
  logic [7 : 0]            bytes [$];
  csi2_rx_pkg::crc16_t     crc;
  csi2_rx_pkg::csi2_word_t w;
  logic [7 : 0]            r;
  int                      pos;
  int                      latency;
  send_word( { next_random_byte(), t.wc, t.di } );  // ECC byte is ignored.
  if( long_data_type( t.di ) )
    begin
      for( int n = 0; n < t.wc; n++ )
        bytes.push_back( next_random_byte() );
      crc = crc16_of( bytes );
      bytes.push_back( crc[7 : 0] );
      bytes.push_back( crc[15 : 8] );
      if( t.corrupt )
        begin
          r   = next_random_byte();
          pos = r % t.wc;
          bytes[pos][r[2 : 0]] = ~bytes[pos][r[2 : 0]];
        end
      for( int n = 0; n < bytes.size(); n += 4 )
        begin
          for( int k = 0; k < 4; k++ )
            if( n + k < bytes.size() )
              w[8 * k +: 8] = bytes[n + k];
            else
              w[8 * k +: 8] = next_random_byte();  // Junk past the tail.
          send_word( w );
        end
    end
  latency = 0;
  do
    begin
      @( posedge clk_i );
      word_valid_i <= 1'b0;
      latency++;
      @( negedge clk_i );
    end
  while( !result_valid_o && latency < 10 );
  checks++;
  assert( result_valid_o )
  else
    begin
      errors++;
      $display( "%s: no result within 10 cycles of the last word", t.name );
    end
  if( result_valid_o )
    begin
      check_field( t.name, "latency", long_data_type( t.di ) ? 3 : 2, latency );
      check_field( t.name, "di", t.di, result_o.di );
      check_field( t.name, "wc", t.wc, result_o.wc );
      check_field( t.name, "is_long", long_data_type( t.di ), result_o.is_long );
      check_field( t.name, "crc_ok", long_data_type( t.di ) && !t.corrupt, result_o.crc_ok );
    end
  repeat( 2 ) @( posedge clk_i );
endtask

initial
  begin
    rst_i        <= 1'b1;
    word_valid_i <= 1'b0;
    word_i       <= '0;
    checks   = 0;
    errors   = 0;
    exp_good = 0;
    exp_bad  = 0;
    repeat( 5 ) @( posedge clk_i );
    rst_i <= 1'b0;
    @( negedge clk_i );
    check_field( "reset", "result_valid", 0, result_valid_o );
    check_field( "reset", "good_cnt", 0, good_cnt_o );
    check_field( "reset", "bad_cnt", 0, bad_cnt_o );
    foreach( tests[t] )
      begin
        run_test( tests[t] );
        if( long_data_type( tests[t].di ) )
          begin
            if( tests[t].corrupt )
              exp_bad++;
            else
              exp_good++;
          end
      end
    @( negedge clk_i );
    check_field( "counters", "good_cnt", exp_good, good_cnt_o );
    check_field( "counters", "bad_cnt", exp_bad, bad_cnt_o );
    $display( "Checks run: %0d, errors: %0d", checks, errors );
    if( errors == 0 )
      $display( "Simulation completed successfully" );
    else
      $display( "Simulation failed" );
    $finish;
  end

// Watchdog.
initial
  begin
    int limit;
    limit = $size( tests ) * ( max_packet_words() + 10 ) + 5;
    repeat( limit ) @( posedge clk_i );
    $display( "Timeout: the run did not finish within %0d cycles", limit );
    $display( "Simulation failed" );
    $finish;
  end

endmodule

//--- csi2_rx.f
rtl/csi2_rx_pkg.sv
rtl/crc_calc.sv
rtl/csi2_crc_calc.sv
rtl/csi2_pkt_decode.sv
rtl/csi2_pkt_result.sv
rtl/csi2_rx_top.sv
verification/csi2_rx_properties.sv
verification/csi2_rx_tb.sv

//--- Bender.yml
package:
  name: csi2_rx

sources:
  - rtl/csi2_rx_pkg.sv
  - rtl/crc_calc.sv
  - rtl/csi2_crc_calc.sv
  - rtl/csi2_pkt_decode.sv
  - rtl/csi2_pkt_result.sv
  - rtl/csi2_rx_top.sv
  - target: test
    files:
      - verification/csi2_rx_properties.sv
      - verification/csi2_rx_tb.sv
